// ==== filelist.f ====
+incdir+design
design/cpu_bus_pkg.sv
design/mapper_pkg.sv
design/cpu_req_capture.sv
design/mapper_konami_scc.sv
design/cart_read_port.sv
design/konami_cart_top.sv
testbench/konami_cart_assertions.sv
testbench/konami_cart_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module konami_cart_tb \
   -o konami_cart_sim &&
./obj_dir/konami_cart_sim ||
{ echo "Simulation build or run failed"; exit 1; }

// ==== testbench/konami_cart_tb.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module konami_cart_tb
   import cpu_bus_pkg::*;
   import mapper_pkg::*;
();

   localparam int N_RAND     = 300;   // Back-to-back random cycles
   localparam int N_DIRECTED = 900;   // Upper bound of directed bus cycles with idles

   // Predicted response of one driven cycle
   typedef struct packed {
      logic      cs;     // rom_cs
      rom_addr_t addr;   // rom_addr
      logic      rd;     // Read that must answer with rd_valid
      cpu_data_t data;   // rd_data
      int        cyc;    // Cycle count when the request was driven
   } expect_t;

   logic        clock_bus;
   logic        rst;
   logic        mreq;
   logic        rd;
   logic        wr;
   cpu_addr_t   addr;
   cpu_data_t   wdata;
   logic        slot_id;
   block_info_t block_info;
   cpu_data_t   rom_rdata;
   logic        rom_cs;
   rom_addr_t   rom_addr;
   cpu_data_t   rd_data;
   logic        rd_valid;
   logic        scc_en;

   integer    seed = 32'hafe0d0c2;
   int        cyc = 0;                        // Rising edges seen
   expect_t   rom_q [$];                      // Waiting for the ROM pins
   expect_t   rd_q [$];                       // Waiting for rd_valid
   cpu_data_t m_banks [`CART_SLOTS][4];       // Model bank registers
   logic      m_scc [`CART_SLOTS];            // Model SCC enable
   cpu_data_t m_wave [`CART_WAVE_BYTES];      // Model wave table

   konami_cart_top dut0 (
      .clock_bus, .rst, .mreq, .rd, .wr, .addr, .wdata, .slot_id, .block_info,
      .rom_rdata, .rom_cs, .rom_addr, .rd_data, .rd_valid, .scc_en
   );

   bind konami_cart_top konami_cart_assertions u_checks (
      .clock_bus, .rst, .rom_cs, .rom_addr, .rd_valid
   );

   // ROM image as the low address byte mixed with the page number
   function automatic cpu_data_t rom_byte(input rom_addr_t a);
      return a[7:0] ^ a[20:13];
   endfunction

   assign rom_rdata = rom_byte(rom_addr);

   initial begin
      clock_bus = 1'b0;
      forever #2 clock_bus = ~clock_bus;   // 4 ns period
   end

   always @(posedge clock_bus) cyc <= cyc + 1;

   task automatic abort_run();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic check_rom_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_data(input string name, input cpu_data_t got, input cpu_data_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_cs(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   // Reference model of one CPU cycle that updates the model state in order
   function automatic expect_t predict(input logic m, input logic r, input logic w,
                                       input cpu_addr_t a, input cpu_data_t d, input logic s);
      expect_t   e;
      logic      match;
      logic      scc_win;
      logic      wave_win;
      logic      mapped;
      rom_addr_t ta;
      match  = (block_info.typ == MAPPER_KONAMI_SCC) && m;
      ta     = '1;
      mapped = 1'b0;
      if ((a >= 16'h4000) && (a <= 16'hBFFF)) begin
         // 8 KB page number times page size plus offset
         ta     = rom_addr_t'(m_banks[s][int'(a[15:13]) - 2]) * rom_addr_t'(8192)
                + rom_addr_t'(a[12:0]);
         mapped = ta < rom_addr_t'(block_info.rom_size);
      end
      scc_win  = (a >= 16'h9800) && (a <= 16'h9FFF) && m_scc[s];
      wave_win = match && scc_win && (a <= 16'h987F);
      e.cs     = match && mapped && !scc_win;
      e.addr   = e.cs ? ta : '1;
      e.rd     = m && r;
      e.data   = e.cs ? rom_byte(ta) : (wave_win ? m_wave[a[6:0]] : 8'hFF);
      e.cyc    = 0;
      if (m && w && wave_win) m_wave[a[6:0]] = d;
      if (m && w && match) begin
         if ((a >= 16'h5000) && (a <= 16'h57FF)) m_banks[s][0] = d;
         if ((a >= 16'h7000) && (a <= 16'h77FF)) m_banks[s][1] = d;
         if ((a >= 16'hB000) && (a <= 16'hB7FF)) m_banks[s][3] = d;
         if ((a >= 16'h9000) && (a <= 16'h97FF)) begin
            m_banks[s][2] = d;
            m_scc[s]      = (d[5:0] == `CART_SCC_CODE);
         end
      end
      return e;
   endfunction

   // One bus cycle driven 1 ns after the edge
   task automatic drive_cycle(input logic m, input logic r, input logic w,
                              input cpu_addr_t a, input cpu_data_t d, input logic s);
      expect_t e;
      mreq    = m;
      rd      = r;
      wr      = w;
      addr    = a;
      wdata   = d;
      slot_id = s;
      e       = predict(m, r, w, a, d, s);
      e.cyc   = cyc;
      rom_q.push_back(e);
      @(posedge clock_bus);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(1'b0, 1'b0, 1'b0, 16'h0000, 8'h00, 1'b0);
   endtask

   // A Z80 read is never followed by another read in the next cycle
   task automatic read_at(input cpu_addr_t a, input logic s);
      drive_cycle(1'b1, 1'b1, 1'b0, a, 8'h00, s);
      idle_cycles(1);
   endtask

   task automatic write_at(input cpu_addr_t a, input cpu_data_t d, input logic s);
      drive_cycle(1'b1, 1'b0, 1'b1, a, d, s);
   endtask

   task automatic set_block(input mapper_type_e typ, input logic [24:0] size);
      idle_cycles(4);   // Pipeline empty while the configuration changes
      block_info.typ      = typ;
      block_info.rom_size = size;
   endtask

   task automatic random_traffic(input int n);
      logic [31:0] rnd;
      logic [31:0] rnd2;
      cpu_addr_t   a;
      cpu_data_t   d;
      logic        m;
      logic        last_rd;
      last_rd = 1'b0;
      for (int i = 0; i < n; i++) begin
         rnd  = $random(seed);
         rnd2 = $random(seed);
         a    = rnd[15:0];
         if (rnd[16]) a[15:14] = rnd[17] ? 2'b10 : 2'b01;     // Mostly inside 4000h-BFFFh
         if (rnd[20:18] == 3'd0) a = {9'b100110000, rnd[6:0]};  // Wave table
         d = rnd2[7:0];
         if (rnd2[8]) d[5:0] = `CART_SCC_CODE;
         m = (rnd2[11:9] != 3'd0);                               // Some stray strobes
         if (!last_rd && rnd[22]) begin
            drive_cycle(m, 1'b1, 1'b0, a, 8'h00, rnd[23]);
            last_rd = 1'b1;
         end else begin
            if (rnd[21]) a[12:11] = 2'b10;   // Bank select ranges
            drive_cycle(m, 1'b0, 1'b1, a, d, rnd[23]);
            last_rd = 1'b0;
         end
      end
   endtask

   // ROM pins are due 2 cycles and read data 3 cycles after the request
   initial begin : compare
      expect_t e;
      forever begin
         @(negedge clock_bus);
         if (!rst) begin
            if ((rom_q.size() > 0) && (rom_q[0].cyc + 2 == cyc)) begin
               e = rom_q.pop_front();
               check_cs("rom_cs", rom_cs, e.cs);
               check_rom_addr("rom_addr", rom_addr, e.addr);
               if (e.rd) rd_q.push_back(e);
            end
            if ((rd_q.size() > 0) && (rd_q[0].cyc + 3 == cyc)) begin
               e = rd_q.pop_front();
               check_cs("rd_valid", rd_valid, 1'b1);
               check_data("rd_data", rd_data, e.data);
            end else begin
               check_cs("rd_valid", rd_valid, 1'b0);
            end
         end
      end
   end

   initial begin : watchdog
      repeat ((N_DIRECTED + N_RAND) * 4 + 200) @(posedge clock_bus);
      $display("Timeout, the test sequence did not complete in time");
      abort_run();
   end

   initial begin : main
      logic [31:0] rnd;
      cpu_addr_t   a;
      rst                 = 1'b1;
      mreq                = 1'b0;
      rd                  = 1'b0;
      wr                  = 1'b0;
      addr                = '0;
      wdata               = '0;
      slot_id             = 1'b0;
      block_info.typ      = MAPPER_KONAMI_SCC;
      block_info.rom_size = 25'h200000;   // 2 MB image
      for (int s = 0; s < `CART_SLOTS; s++) begin
         m_scc[s] = 1'b0;
         for (int b = 0; b < 4; b++) m_banks[s][b] = 8'(b);
      end
      repeat (8) @(posedge clock_bus);
      #1;
      rst = 1'b0;
      check_cs("rom_cs", rom_cs, 1'b0);
      check_cs("rd_valid", rd_valid, 1'b0);
      check_cs("scc_en", scc_en, 1'b0);
      check_rom_addr("rom_addr", rom_addr, '1);

      // Reset layout with pages 0-3 in both slots
      for (int s = 0; s < `CART_SLOTS; s++) begin
         for (int w = 0; w < 4; w++) read_at(cpu_addr_t'(16'h4000 + w * 16'h2000), 1'(s));
      end

      // Bank switching per slot
      for (int round = 0; round < 2; round++) begin
         for (int s = 0; s < `CART_SLOTS; s++) begin
            for (int w = 0; w < 4; w++) begin
               rnd = $random(seed);
               write_at(cpu_addr_t'(16'h5000 + w * 16'h2000), rnd[7:0], 1'(s));
            end
         end
         for (int s = 0; s < `CART_SLOTS; s++) begin
            for (int w = 0; w < 4; w++) begin
               rnd = $random(seed);
               read_at(cpu_addr_t'(16'h4000 + w * 16'h2000 + int'(rnd[10:0])), 1'(s));
            end
         end
      end

      // SCC window open in slot 0
      write_at(16'h9000, 8'h3F, 1'b0);
      idle_cycles(3);
      check_cs("scc_en", scc_en, 1'b1);
      for (int i = 0; i < `CART_WAVE_BYTES; i++) begin
         rnd = $random(seed);
         write_at(cpu_addr_t'(16'h9800 + i), rnd[7:0], 1'b0);
      end
      for (int i = 0; i < `CART_WAVE_BYTES; i++) read_at(cpu_addr_t'(16'h9800 + i), 1'b0);
      read_at(16'h9880, 1'b0);
      read_at(16'h9FFF, 1'b0);
      repeat (8) begin
         rnd = $random(seed);
         a   = {5'b10011, rnd[10:0]};
         if (a < 16'h9880) a[7] = 1'b1;   // Past the wave table
         read_at(a, 1'b0);
      end
      read_at(16'h9800, 1'b1);            // Slot 1 keeps its own SCC flag
      write_at(16'h9000, 8'h05, 1'b0);
      idle_cycles(3);
      check_cs("scc_en", scc_en, 1'b0);
      read_at(16'h9800, 1'b0);

      // Unmapped cycles
      read_at(16'h0000, 1'b0);
      read_at(16'h3FFF, 1'b0);
      read_at(16'hC000, 1'b1);
      read_at(16'hFFFF, 1'b1);
      set_block(MAPPER_KONAMI_SCC, 25'h10000);   // 64 KB, pages 0-7
      write_at(16'h5000, 8'h20, 1'b0);
      read_at(16'h4000, 1'b0);
      read_at(16'h6000, 1'b0);
      set_block(MAPPER_KONAMI, 25'h200000);
      read_at(16'h6000, 1'b0);
      write_at(16'h7000, 8'h11, 1'b0);
      write_at(16'h9000, 8'h3F, 1'b0);
      set_block(MAPPER_NONE, 25'h200000);
      read_at(16'hA000, 1'b1);
      set_block(MAPPER_KONAMI_SCC, 25'h200000);
      read_at(16'h6000, 1'b0);
      idle_cycles(3);
      check_cs("scc_en", scc_en, 1'b0);

      // Random traffic with one cycle after another
      set_block(MAPPER_KONAMI_SCC, 25'h100000);
      random_traffic(N_RAND);
      idle_cycles(6);
      repeat (2) @(posedge clock_bus);   // Last two idle cycles still in the ROM stage
      #1;

      if ((rom_q.size() != 0) || (rd_q.size() != 0)) begin
         $display("Expected responses were still outstanding at the end of the run");
         abort_run();
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

// ==== testbench/konami_cart_assertions.sv ====
`timescale 1ns/1ps

module konami_cart_assertions
   import mapper_pkg::*;
(
   input logic      clock_bus,
   input logic      rst,
   input logic      rom_cs,
   input rom_addr_t rom_addr,
   input logic      rd_valid
);

   // One response cycle per read strobe
   property single_valid;
      @(posedge clock_bus) disable iff (rst) rd_valid |=> !rd_valid;
   endproperty

   // Idle ROM bus is parked at all ones
   property idle_addr;
      @(posedge clock_bus) disable iff (rst) !rom_cs |-> (rom_addr == '1);
   endproperty

   property cs_after_reset;
      @(posedge clock_bus) rst |=> !rom_cs;
   endproperty

   a_single_valid: assert property (single_valid)
      else $error("rd_valid stayed high for two cycles");
   a_idle_addr: assert property (idle_addr)
      else $error("rom_addr not all ones while rom_cs is low");
   a_cs_after_reset: assert property (cs_after_reset)
      else $error("rom_cs high in the cycle after reset");

endmodule

// ==== design/konami_cart_top.sv ====
`timescale 1ns/1ps

module konami_cart_top
   import cpu_bus_pkg::*;
   import mapper_pkg::*;
(
   input  logic        clock_bus,
   input  logic        rst,
   input  logic        mreq,
   input  logic        rd,
   input  logic        wr,
   input  cpu_addr_t   addr,
   input  cpu_data_t   wdata,
   input  logic        slot_id,
   input  block_info_t block_info,
   input  cpu_data_t   rom_rdata,    // From the external ROM
   output logic        rom_cs,
   output rom_addr_t   rom_addr,
   output cpu_data_t   rd_data,
   output logic        rd_valid,
   output logic        scc_en
);

   cpu_req_t q_req;     // Registered CPU cycle
   rom_req_t map_req;   // Mapper decision
   dev_sel_t dev_typ;

   cpu_req_capture u_capture (
      .clock_bus, .rst, .mreq, .rd, .wr, .addr, .wdata, .slot_id,
      .q_req
   );

   mapper_konami_scc u_mapper (
      .clock_bus, .rst, .q_req, .block_info,
      .map_req, .dev_typ, .scc_en
   );

   cart_read_port u_read_port (
      .clock_bus, .rst, .map_req, .dev_typ,
      .addr (q_req.addr), .wdata (q_req.wdata), .wr (q_req.wr),
      .rom_rdata, .rom_cs, .rom_addr, .rd_data, .rd_valid
   );

endmodule

// ==== design/cart_read_port.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_read_port
   import cpu_bus_pkg::*;
   import mapper_pkg::*;
(
   input  logic      clock_bus,
   input  logic      rst,
   input  rom_req_t  map_req,     // Mapper decision for the current cycle
   input  dev_sel_t  dev_typ,     // SCC present only for a matching type
   input  cpu_addr_t addr,        // CPU address of the same cycle
   input  cpu_data_t wdata,
   input  logic      wr,
   input  cpu_data_t rom_rdata,   // Combinational from rom_addr
   output logic      rom_cs,
   output rom_addr_t rom_addr,
   output cpu_data_t rd_data,
   output logic      rd_valid
);

   localparam int WAVE_AW = $clog2(`CART_WAVE_BYTES);

   cpu_data_t wave_ram [`CART_WAVE_BYTES];   // 4 channels x 32 samples

   logic               wave_hit;    // 9800h-987Fh with the SCC open
   logic [WAVE_AW-1:0] wave_idx;
   logic               s1_rd;       // Read in flight, aligned with rom_addr
   logic               s1_wave;     // That read targets the wave RAM
   cpu_data_t          s1_wave_q;   // Wave RAM read data

   // A10-A7 zero inside 9800h-9FFFh means the 128-byte wave table
   assign wave_hit = map_req.scc_sel && (dev_typ == DEV_SCC) && (addr[10:WAVE_AW] == '0);
   assign wave_idx = addr[WAVE_AW-1:0];

   // Stage 1, ROM request to the pins
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         rom_cs   <= 1'b0;
         rom_addr <= '1;
         s1_rd    <= 1'b0;
      end else begin
         rom_cs   <= map_req.ram_cs;
         rom_addr <= map_req.addr;
         s1_rd    <= map_req.rd;
      end
   end

   // Read kind and wave sample travel with the ROM stage
   always_ff @(posedge clock_bus) begin
      s1_wave   <= wave_hit;
      s1_wave_q <= wave_ram[wave_idx];
   end

   // Wave table write port
   always_ff @(posedge clock_bus) begin
      if (wave_hit && wr) begin
         wave_ram[wave_idx] <= wdata;
      end
   end

   // Stage 2, read data back to the CPU
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= s1_rd;   // Single pulse per read
      end
   end

   always_ff @(posedge clock_bus) begin
      if (rom_cs) begin
         rd_data <= rom_rdata;
      end else if (s1_wave) begin
         rd_data <= s1_wave_q;
      end else begin
         rd_data <= 8'hFF;   // Open bus
      end
   end

endmodule

// ==== design/mapper_konami_scc.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module mapper_konami_scc
   import cpu_bus_pkg::*;
   import mapper_pkg::*;
(
   input  logic        clock_bus,
   input  logic        rst,
   input  cpu_req_t    q_req,        // Registered CPU cycle
   input  block_info_t block_info,   // Mapper type and ROM size
   output rom_req_t    map_req,      // Translation, valid in the q_req cycle
   output dev_sel_t    dev_typ,      // Device owning the cycle
   output logic        scc_en        // SCC open in the addressed slot
);

   typedef logic [7:0] bank_num_t;   // 8 KB page number

   // Four switchable 8 KB windows per slot
   // Index 0 covers 4000h-5FFFh, index 3 covers A000h-BFFFh
   bank_num_t              banks [`CART_SLOTS][4];
   logic [`CART_SLOTS-1:0] scc_enable;   // One flag per slot

   logic       cs;          // Type matches and a cycle is present
   logic       in_window;   // 4000h-BFFFh
   logic       mapped;      // In window and inside the ROM image
   logic       scc_area;    // 9800h-9FFFh with SCC open
   logic       bank_wr;     // Write to one of the bank select ranges
   logic [1:0] bank_idx;    // Window addressed by A15-A13
   bank_num_t  bank_base;
   rom_addr_t  rom_addr;

   assign cs        = (block_info.typ == MAPPER_KONAMI_SCC) && q_req.mreq;
   assign in_window = (q_req.addr >= 16'h4000) && (q_req.addr < 16'hC000);

   // 010 -> 0, 011 -> 1, 100 -> 2, 101 -> 3
   assign bank_idx  = 2'(q_req.addr[15:13] - 3'd2);
   assign bank_base = banks[q_req.slot][bank_idx];

   // Page number on top of the 13-bit offset, zero extended
   assign rom_addr = rom_addr_t'({bank_base, q_req.addr[12:0]});

   assign mapped   = in_window && (rom_addr < rom_addr_t'(block_info.rom_size));
   assign scc_area = (q_req.addr[15:11] == 5'b10011) && scc_enable[q_req.slot];

   // 5000h, 7000h, 9000h and B000h ranges all have A12-A11 = 10
   assign bank_wr = cs && q_req.wr && in_window && (q_req.addr[12:11] == 2'b10);

   always_comb begin
      map_req.ram_cs  = cs && mapped && !scc_area;
      map_req.addr    = map_req.ram_cs ? rom_addr : '1;   // Idle bus reads as all ones
      map_req.rd      = q_req.rd;                         // Every read gets an answer
      map_req.scc_sel = q_req.mreq && scc_area;           // Type checked at the wave RAM
   end

   assign dev_typ = cs ? DEV_SCC : DEV_NONE;
   assign scc_en  = scc_enable[q_req.slot];

   // Bank select and SCC enable registers
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         for (int s = 0; s < `CART_SLOTS; s++) begin
            for (int b = 0; b < 4; b++) begin
               banks[s][b] <= bank_num_t'(b);   // Linear layout of the first 32 KB
            end
         end
         scc_enable <= '0;
      end else if (bank_wr) begin
         banks[q_req.slot][bank_idx] <= q_req.wdata;
         if (bank_idx == 2'd2) begin   // 9000h range also opens or closes the SCC
            scc_enable[q_req.slot] <= (q_req.wdata[5:0] == `CART_SCC_CODE);
         end
      end
   end

endmodule

// ==== design/cpu_req_capture.sv ====
`timescale 1ns/1ps

module cpu_req_capture
   import cpu_bus_pkg::*;
(
   input  logic      clock_bus,
   input  logic      rst,
   input  logic      mreq,      // Memory request from the Z80
   input  logic      rd,        // Read strobe
   input  logic      wr,        // Write strobe
   input  cpu_addr_t addr,
   input  cpu_data_t wdata,
   input  logic      slot_id,   // Slot decoded by the primary slot logic
   output cpu_req_t  q_req      // Registered cycle, one clock later
);

   // Strobes and slot select, cleared on reset
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         q_req.mreq <= 1'b0;
         q_req.rd   <= 1'b0;
         q_req.wr   <= 1'b0;
         q_req.slot <= 1'b0;   // Keeps scc_en defined out of reset
      end else begin
         q_req.mreq <= mreq;
         q_req.rd   <= rd & mreq;   // Stray strobe without mreq is dropped
         q_req.wr   <= wr & mreq;
         q_req.slot <= slot_id;
      end
   end

   // Address and data just follow the bus
   always_ff @(posedge clock_bus) begin
      q_req.addr  <= addr;
      q_req.wdata <= wdata;
   end

endmodule

// ==== design/mapper_pkg.sv ====
`include "cart_settings.svh"

package mapper_pkg;

   // Byte address on the ROM side
   typedef logic [`CART_ROM_ADDR_W-1:0] rom_addr_t;

   // Mapper type the slot is configured with
   typedef enum logic [1:0] {
      MAPPER_NONE       = 2'd0,
      MAPPER_KONAMI     = 2'd1,
      MAPPER_KONAMI_SCC = 2'd2
   } mapper_type_e;

   // Static configuration of the cartridge slot
   typedef struct packed {
      mapper_type_e typ;        // Selected mapper
      logic [24:0]  rom_size;   // ROM image size in bytes
   } block_info_t;

   // Mapper decision for one CPU cycle
   typedef struct packed {
      logic      ram_cs;    // ROM access
      rom_addr_t addr;      // All ones when ram_cs is low
      logic      rd;        // Cycle is a read
      logic      scc_sel;   // Cycle lands in the open SCC window
   } rom_req_t;

   // Which on-cartridge device owns the cycle
   typedef enum logic {DEV_NONE, DEV_SCC} dev_sel_t;

endpackage

// ==== design/cpu_bus_pkg.sv ====
`include "cart_settings.svh"

package cpu_bus_pkg;

   // Z80 memory address
   typedef logic [`CART_ADDR_W-1:0] cpu_addr_t;

   // Z80 data byte
   typedef logic [7:0] cpu_data_t;

   // One sampled CPU memory cycle
   // rd and wr are already qualified with mreq when this is built
   typedef struct packed {
      logic      mreq;    // Memory request
      logic      rd;      // Read strobe, one cycle
      logic      wr;      // Write strobe, one cycle
      cpu_addr_t addr;    // Full 16-bit address
      cpu_data_t wdata;   // Write data
      logic      slot;    // Which slot the cycle is decoded for
   } cpu_req_t;

endpackage

// ==== design/cart_settings.svh ====
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// Z80 side address bus width
`define CART_ADDR_W 16

// Byte address into the cartridge ROM, up to 128 MB
`define CART_ROM_ADDR_W 27

// Independent mapper contexts, one per cartridge slot
`define CART_SLOTS 2

// SCC waveform RAM, 4 channels x 32 bytes
`define CART_WAVE_BYTES 128

`define CART_SCC_CODE 6'h3F   // Low 6 bits of a bank 3 write that open the SCC

`endif
